//--- rtl/bridge_defines.svh
`ifndef BRIDGE_DEFINES_SVH
`define BRIDGE_DEFINES_SVH

// serial word width on both UART paths
`define BRIDGE_DATA_WIDTH 32

// control frame is start pattern, slave id, read/write bit
`define BRIDGE_ID_WIDTH 2
`define BRIDGE_FRAME_LEN 6

// acknowledge codes exchanged with the neighbour boards
`define BRIDGE_ACK_BYTE 8'hCC
`define BRIDGE_NAK_BYTE 8'hAA

// default acknowledge wait in cycles and retry limit
`define BRIDGE_ACK_TIMEOUT 1000000
`define BRIDGE_RETRANSMITS 5

`endif

//--- rtl/bridge_pkg.sv
`default_nettype none

package bridge_pkg;

    // upper nibble of the ACK or NAK code, returned to the master
    typedef logic [3:0] status_nibble_t;

    // control frame decoder
    typedef enum logic {
        dec_listen,
        dec_shift
    } dec_state_t;

    // transfer sequencer
    typedef enum logic [1:0] {
        seq_idle,
        seq_write,
        seq_read
    } seq_state_t;

    // write path toward the send UART
    typedef enum logic [1:0] {
        wr_collect,
        wr_launch,
        wr_wait_ack,
        wr_report
    } wr_state_t;

endpackage

`default_nettype wire

//--- rtl/ctrl_frame_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "bridge_defines.svh"

module ctrl_frame_decoder #(
    parameter logic [`BRIDGE_ID_WIDTH-1:0] SLAVE_ID = 1
) (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic enable,
    output logic cmd_valid,
    output logic cmd_write
);
    import bridge_pkg::*;

    localparam int FL    = `BRIDGE_FRAME_LEN;
    localparam int IDW   = `BRIDGE_ID_WIDTH;
    localparam int CNT_W = $clog2(FL);

    dec_state_t       state;
    logic [CNT_W-1:0] bit_cnt;
    logic [FL-2:0]    history;
    logic [FL-1:0]    frame;
    logic             frame_ok;

    // current bit completes the frame on the last shift cycle
    assign frame    = {history, control};
    assign frame_ok = (&frame[FL-1:IDW+1]) && (frame[IDW:1] == SLAVE_ID);

    always_ff @(posedge clk) begin
        history <= {history[FL-3:0], control};
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= dec_listen;
            bit_cnt   <= '0;
            cmd_valid <= 1'b0;
            cmd_write <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;
            case (state)
                dec_listen: begin
                    // first high bit is the first start bit
                    if (enable && control) begin
                        bit_cnt <= CNT_W'(1);
                        state   <= dec_shift;
                    end
                end
                dec_shift: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == CNT_W'(FL - 1)) begin
                        cmd_valid <= frame_ok;
                        cmd_write <= control;
                        state     <= dec_listen;
                    end
                end
                default: state <= dec_listen;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/bridge_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module bridge_sequencer (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       cmd_valid,
    input  logic                       cmd_write,
    input  logic                       wr_accepting,
    input  logic                       wr_done,
    input  bridge_pkg::status_nibble_t wr_status,
    input  logic                       rd_streaming,
    input  logic                       rd_done,
    output logic                       decoder_enable,
    output logic                       wr_start,
    output logic                       rd_start,
    output bridge_pkg::status_nibble_t last_status,
    output logic                       ready
);
    import bridge_pkg::*;

    seq_state_t state;
    logic       after_done;

    // no new frame while a command is being dispatched or a transfer runs
    assign decoder_enable = (state == seq_idle) && !cmd_valid;

    // one low cycle after each transfer marks its end to the master
    assign ready = !after_done && ((state == seq_idle) || wr_accepting || rd_streaming);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state       <= seq_idle;
            wr_start    <= 1'b0;
            rd_start    <= 1'b0;
            after_done  <= 1'b0;
            last_status <= '0;
        end else begin
            wr_start   <= 1'b0;
            rd_start   <= 1'b0;
            after_done <= wr_done || rd_done;
            case (state)
                seq_idle: begin
                    if (cmd_valid && cmd_write) begin
                        wr_start <= 1'b1;
                        state    <= seq_write;
                    end else if (cmd_valid) begin
                        rd_start <= 1'b1;
                        state    <= seq_read;
                    end
                end
                seq_write: begin
                    // result is kept for the status nibble of the next read
                    if (wr_done) begin
                        last_status <= wr_status;
                        state       <= seq_idle;
                    end
                end
                seq_read: begin
                    if (rd_done) begin
                        state <= seq_idle;
                    end
                end
                default: state <= seq_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/write_forwarder.sv
`timescale 1ns/1ps
`default_nettype none
`include "bridge_defines.svh"

module write_forwarder #(
    parameter int unsigned ACK_TIMEOUT      = `BRIDGE_ACK_TIMEOUT,
    parameter int unsigned RETRANSMIT_TIMES = `BRIDGE_RETRANSMITS
) (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          wr_start,
    input  logic                          wD,
    input  logic                          valid,
    input  logic                          s_tx_ready,
    input  logic                          s_rx_done,
    input  logic [`BRIDGE_DATA_WIDTH-1:0] s_byte_from_rx,
    output logic                          wr_accepting,
    output logic                          s_tx_start,
    output logic [`BRIDGE_DATA_WIDTH-1:0] s_byte_for_tx,
    output logic                          wr_done,
    output bridge_pkg::status_nibble_t    wr_status
);
    import bridge_pkg::*;

    localparam int W     = `BRIDGE_DATA_WIDTH;
    localparam int CNT_W = $clog2(W);
    localparam int TMR_W = $clog2(ACK_TIMEOUT + 1);
    localparam int RTY_W = (RETRANSMIT_TIMES > 0) ? $clog2(RETRANSMIT_TIMES + 1) : 1;

    localparam logic [7:0] ACK_CODE = `BRIDGE_ACK_BYTE;
    localparam logic [7:0] NAK_CODE = `BRIDGE_NAK_BYTE;

    wr_state_t        state;
    logic             active;
    logic [CNT_W-1:0] bit_cnt;
    logic [W-2:0]     shift_q;
    logic [TMR_W-1:0] timer;
    logic [RTY_W-1:0] retries;
    logic             accept;
    logic             last_bit;
    logic             timed_out;

    // the wr_start cycle already takes a bit
    assign wr_accepting = (state == wr_collect) && (active || wr_start);
    assign accept       = wr_accepting && valid;
    assign last_bit     = accept && (bit_cnt == CNT_W'(W - 1));
    assign s_tx_start   = (state == wr_launch) && s_tx_ready;
    assign timed_out    = (timer == TMR_W'(ACK_TIMEOUT - 1));
    assign wr_done      = (state == wr_report);

    // MSB first
    always_ff @(posedge clk) begin
        if (accept) begin
            shift_q <= {shift_q[W-3:0], wD};
        end
        if (last_bit) begin
            s_byte_for_tx <= {shift_q, wD};
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= wr_collect;
            active    <= 1'b0;
            bit_cnt   <= '0;
            timer     <= '0;
            retries   <= '0;
            wr_status <= '0;
        end else begin
            case (state)
                wr_collect: begin
                    if (wr_start) begin
                        active  <= 1'b1;
                        retries <= '0;
                    end
                    // counter wraps back to zero on the last bit
                    if (accept) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                    if (last_bit) begin
                        state <= wr_launch;
                    end
                end
                wr_launch: begin
                    if (s_tx_ready) begin
                        timer <= '0;
                        state <= wr_wait_ack;
                    end
                end
                wr_wait_ack: begin
                    if (s_rx_done) begin
                        wr_status <= (s_byte_from_rx[7:0] == ACK_CODE) ?
                                     ACK_CODE[7:4] : NAK_CODE[7:4];
                        state     <= wr_report;
                    end else if (timed_out && retries == RTY_W'(RETRANSMIT_TIMES)) begin
                        // remote never answered
                        wr_status <= NAK_CODE[7:4];
                        state     <= wr_report;
                    end else if (timed_out) begin
                        retries <= retries + 1'b1;
                        state   <= wr_launch;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                wr_report: begin
                    active <= 1'b0;
                    state  <= wr_collect;
                end
                default: state <= wr_collect;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/read_responder.sv
`timescale 1ns/1ps
`default_nettype none
`include "bridge_defines.svh"

module read_responder (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          rd_start,
    input  bridge_pkg::status_nibble_t    last_status,
    input  logic                          g_rx_done,
    input  logic [`BRIDGE_DATA_WIDTH-1:0] g_byte_from_rx,
    input  logic                          g_tx_ready,
    output logic                          g_tx_start,
    output logic [`BRIDGE_DATA_WIDTH-1:0] g_byte_for_tx,
    output logic                          rd_streaming,
    output logic                          rD,
    output logic                          rd_done
);
    import bridge_pkg::*;

    localparam int W          = `BRIDGE_DATA_WIDTH;
    localparam int STREAM_LEN = W + $bits(status_nibble_t);
    localparam int SCNT_W     = $clog2(STREAM_LEN);

    localparam logic [7:0] ACK_CODE = `BRIDGE_ACK_BYTE;

    logic                  waiting;
    logic                  ack_pending;
    logic                  capture;
    logic [SCNT_W-1:0]     stream_cnt;
    logic [STREAM_LEN-1:0] stream_q;

    assign capture    = waiting && g_rx_done;
    assign g_tx_start = ack_pending && g_tx_ready;
    assign rd_done    = rd_streaming && (stream_cnt == SCNT_W'(STREAM_LEN - 1));
    assign rD         = rd_streaming && stream_q[STREAM_LEN-1];

    // status nibble sits above the data word, both shifted out MSB first
    always_ff @(posedge clk) begin
        if (rd_start) begin
            stream_q[STREAM_LEN-1:W] <= last_status;
        end else if (capture) begin
            stream_q[W-1:0] <= g_byte_from_rx;
        end else if (rd_streaming) begin
            stream_q <= {stream_q[STREAM_LEN-2:0], 1'b0};
        end
        if (capture) begin
            g_byte_for_tx <= W'(ACK_CODE);
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            waiting      <= 1'b0;
            ack_pending  <= 1'b0;
            rd_streaming <= 1'b0;
            stream_cnt   <= '0;
        end else begin
            if (rd_start) begin
                waiting <= 1'b1;
            end
            if (capture) begin
                waiting     <= 1'b0;
                ack_pending <= 1'b1;
            end
            // stream starts the cycle after the ACK goes out
            if (g_tx_start) begin
                ack_pending  <= 1'b0;
                rd_streaming <= 1'b1;
                stream_cnt   <= '0;
            end
            if (rd_streaming) begin
                stream_cnt <= stream_cnt + 1'b1;
            end
            if (rd_done) begin
                rd_streaming <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/uart_bridge_slave.sv
`timescale 1ns/1ps
`default_nettype none
`include "bridge_defines.svh"

module uart_bridge_slave #(
    parameter logic [`BRIDGE_ID_WIDTH-1:0] SLAVE_ID         = 1,
    parameter int unsigned                 ACK_TIMEOUT      = `BRIDGE_ACK_TIMEOUT,
    parameter int unsigned                 RETRANSMIT_TIMES = `BRIDGE_RETRANSMITS
) (
    input  logic                          clk,
    input  logic                          rstN,
    // master side
    input  logic                          control,
    input  logic                          wD,
    input  logic                          valid,
    output logic                          ready,
    output logic                          rD,
    // send UART toward the next board
    output logic                          s_tx_start,
    output logic [`BRIDGE_DATA_WIDTH-1:0] s_byte_for_tx,
    input  logic                          s_tx_ready,
    input  logic                          s_rx_done,
    input  logic [`BRIDGE_DATA_WIDTH-1:0] s_byte_from_rx,
    // get UART from the previous board
    output logic                          g_tx_start,
    output logic [`BRIDGE_DATA_WIDTH-1:0] g_byte_for_tx,
    input  logic                          g_tx_ready,
    input  logic                          g_rx_done,
    input  logic [`BRIDGE_DATA_WIDTH-1:0] g_byte_from_rx
);
    import bridge_pkg::*;

    logic           cmd_valid;
    logic           cmd_write;
    logic           decoder_enable;
    logic           wr_start;
    logic           wr_accepting;
    logic           wr_done;
    status_nibble_t wr_status;
    logic           rd_start;
    logic           rd_streaming;
    logic           rd_done;
    status_nibble_t last_status;

    ctrl_frame_decoder #(
        .SLAVE_ID (SLAVE_ID)
    ) i_decoder (
        .clk       (clk),
        .rstN      (rstN),
        .control   (control),
        .enable    (decoder_enable),
        .cmd_valid (cmd_valid),
        .cmd_write (cmd_write)
    );

    bridge_sequencer i_sequencer (
        .clk            (clk),
        .rstN           (rstN),
        .cmd_valid      (cmd_valid),
        .cmd_write      (cmd_write),
        .wr_accepting   (wr_accepting),
        .wr_done        (wr_done),
        .wr_status      (wr_status),
        .rd_streaming   (rd_streaming),
        .rd_done        (rd_done),
        .decoder_enable (decoder_enable),
        .wr_start       (wr_start),
        .rd_start       (rd_start),
        .last_status    (last_status),
        .ready          (ready)
    );

    write_forwarder #(
        .ACK_TIMEOUT      (ACK_TIMEOUT),
        .RETRANSMIT_TIMES (RETRANSMIT_TIMES)
    ) i_write_forwarder (
        .clk            (clk),
        .rstN           (rstN),
        .wr_start       (wr_start),
        .wD             (wD),
        .valid          (valid),
        .s_tx_ready     (s_tx_ready),
        .s_rx_done      (s_rx_done),
        .s_byte_from_rx (s_byte_from_rx),
        .wr_accepting   (wr_accepting),
        .s_tx_start     (s_tx_start),
        .s_byte_for_tx  (s_byte_for_tx),
        .wr_done        (wr_done),
        .wr_status      (wr_status)
    );

    read_responder i_read_responder (
        .clk            (clk),
        .rstN           (rstN),
        .rd_start       (rd_start),
        .last_status    (last_status),
        .g_rx_done      (g_rx_done),
        .g_byte_from_rx (g_byte_from_rx),
        .g_tx_ready     (g_tx_ready),
        .g_tx_start     (g_tx_start),
        .g_byte_for_tx  (g_byte_for_tx),
        .rd_streaming   (rd_streaming),
        .rD             (rD),
        .rd_done        (rd_done)
    );

endmodule

`default_nettype wire

//--- bench/uart_bridge_slave_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "bridge_defines.svh"

module tb_uart_bridge_slave;

    localparam int W                = `BRIDGE_DATA_WIDTH;
    localparam int FL               = `BRIDGE_FRAME_LEN;
    localparam int SLAVE_ID         = 1;
    localparam int ACK_TIMEOUT      = 20;
    localparam int RETRANSMIT_TIMES = 2;
    localparam int NUM_LINES        = 12;
    localparam int FIELDS           = 5;
    localparam int ACK_DELAY        = 5;
    localparam int STREAM_LEN       = W + 4;
    localparam int CYCLE_LIMIT      = NUM_LINES * (80 + 3 * 24);

    logic         clk;
    logic         rstN;
    logic         control;
    logic         wD;
    logic         valid;
    logic         ready;
    logic         rD;
    logic         s_tx_start;
    logic [W-1:0] s_byte_for_tx;
    logic         s_tx_ready;
    logic         s_rx_done;
    logic [W-1:0] s_byte_from_rx;
    logic         g_tx_start;
    logic [W-1:0] g_byte_for_tx;
    logic         g_tx_ready;
    logic         g_rx_done;
    logic [W-1:0] g_byte_from_rx;

    logic [W-1:0] stim [0:NUM_LINES*FIELDS-1];
    logic [7:0]   ack_mode;
    logic [W-1:0] s_last_word;
    logic [W-1:0] g_last_word;
    int           s_tx_count;
    int           g_tx_count;
    int           s_wait;
    int           err_count;
    int           cycle_count;

    uart_bridge_slave #(
        .SLAVE_ID         (SLAVE_ID),
        .ACK_TIMEOUT      (ACK_TIMEOUT),
        .RETRANSMIT_TIMES (RETRANSMIT_TIMES)
    ) i_uart_bridge_slave (
        .clk            (clk),
        .rstN           (rstN),
        .control        (control),
        .wD             (wD),
        .valid          (valid),
        .ready          (ready),
        .rD             (rD),
        .s_tx_start     (s_tx_start),
        .s_byte_for_tx  (s_byte_for_tx),
        .s_tx_ready     (s_tx_ready),
        .s_rx_done      (s_rx_done),
        .s_byte_from_rx (s_byte_from_rx),
        .g_tx_start     (g_tx_start),
        .g_byte_for_tx  (g_byte_for_tx),
        .g_tx_ready     (g_tx_ready),
        .g_rx_done      (g_rx_done),
        .g_byte_from_rx (g_byte_from_rx)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("** FAIL **");
            $finish;
        end
    end

    // remote boards, sampled on the falling edge
    always @(negedge clk) begin
        if (s_tx_start) begin
            s_tx_count  = s_tx_count + 1;
            s_last_word = s_byte_for_tx;
            s_wait      = (ack_mode != 8'h00) ? ACK_DELAY : 0;
        end else if (s_wait > 0) begin
            s_wait = s_wait - 1;
        end
        if (g_tx_start) begin
            g_tx_count  = g_tx_count + 1;
            g_last_word = g_byte_for_tx;
        end
    end

    // acknowledge byte arrives a fixed delay after the send pulse
    always @(posedge clk) begin
        s_rx_done <= (s_wait == 1);
    end

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
        err_count = err_count + 1;
    endtask

    task automatic report_failure(input string what);
        $display("error: %s at %0t", what, $time);
        err_count = err_count + 1;
    endtask

    task automatic send_frame(input logic [1:0] id, input logic rw, input logic bad_start);
        logic [FL-1:0] frame;
        int            k;
        frame = {(bad_start ? 3'b101 : 3'b111), id, rw};
        for (k = FL - 1; k >= 0; k--) begin
            @(posedge clk);
            control <= frame[k];
        end
        @(posedge clk);
        control <= 1'b0;
    endtask

    task automatic wait_ready_high();
        @(negedge clk);
        while (!ready) begin
            @(negedge clk);
        end
    endtask

    // MSB first, with a short pause in valid halfway
    task automatic shift_in_word(input logic [W-1:0] word);
        int bit_idx;
        int gap;
        bit_idx = W - 1;
        gap     = 0;
        while (bit_idx >= 0) begin
            @(posedge clk);
            if (bit_idx == 15 && gap < 3) begin
                valid <= 1'b0;
                wD    <= ~word[bit_idx];
                gap   = gap + 1;
            end else begin
                valid   <= 1'b1;
                wD      <= word[bit_idx];
                bit_idx = bit_idx - 1;
            end
            @(negedge clk);
            if (!ready) begin
                report_failure("ready dropped while write data was being shifted in");
            end
        end
        @(posedge clk);
        valid <= 1'b0;
        wD    <= 1'b0;
    endtask

    task automatic read_stream(input logic [W-1:0] word, input logic [3:0] nibble);
        logic [STREAM_LEN-1:0] expected;
        logic [STREAM_LEN-1:0] got;
        int                    k;
        expected = {nibble, word};
        repeat (4) @(posedge clk);
        g_rx_done      <= 1'b1;
        g_byte_from_rx <= word;
        @(negedge clk);
        if (ready) begin
            report_failure("ready stayed high after the read command");
        end
        @(posedge clk);
        g_rx_done <= 1'b0;
        wait_ready_high();
        for (k = 0; k < STREAM_LEN; k++) begin
            if (k > 0) begin
                @(negedge clk);
            end
            if (!ready) begin
                report_failure("ready dropped inside the read stream");
            end
            got[STREAM_LEN-1-k] = rD;
        end
        @(negedge clk);
        if (ready) begin
            report_failure("ready did not drop for one cycle after the read stream");
        end
        @(negedge clk);
        if (!ready) begin
            report_failure("slave not idle after the read");
        end
        if (got !== expected) begin
            report_mismatch("rD", got, expected);
        end
    endtask

    task automatic watch_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (!ready || rD) begin
                report_failure("slave reacted to a frame it should ignore");
            end
        end
    endtask

    initial begin
        int           n;
        int           s_before;
        int           g_before;
        int           exp_pulses;
        logic [1:0]   op;
        logic [1:0]   id;
        logic [W-1:0] word;
        logic [7:0]   ack;
        logic [3:0]   nibble;
        rstN           = 1'b0;
        control        = 1'b0;
        wD             = 1'b0;
        valid          = 1'b0;
        s_tx_ready     = 1'b1;
        g_tx_ready     = 1'b1;
        s_rx_done      = 1'b0;
        s_byte_from_rx = '0;
        g_rx_done      = 1'b0;
        g_byte_from_rx = '0;
        ack_mode       = 8'h00;
        s_tx_count     = 0;
        g_tx_count     = 0;
        s_wait         = 0;
        err_count      = 0;
        cycle_count    = 0;
        $readmemh("bench/bridge_stim.txt", stim);
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        watch_idle(4);
        if (s_tx_count != 0 || g_tx_count != 0) begin
            report_failure("tx start pulse seen before the first frame");
        end
        for (n = 0; n < NUM_LINES; n++) begin
            op       = stim[n*FIELDS][1:0];
            id       = stim[n*FIELDS+1][1:0];
            word     = stim[n*FIELDS+2];
            ack      = stim[n*FIELDS+3][7:0];
            nibble   = stim[n*FIELDS+4][3:0];
            s_before = s_tx_count;
            g_before = g_tx_count;
            @(posedge clk);
            s_byte_from_rx <= W'(ack);
            ack_mode       <= ack;
            send_frame(id, op[0], op[1]);
            if (op[1] || id != SLAVE_ID) begin
                watch_idle(12);
                if (s_tx_count != s_before || g_tx_count != g_before) begin
                    report_failure("ignored frame caused a tx start pulse");
                end
            end else if (op[0]) begin
                shift_in_word(word);
                wait_ready_high();
                // a silent remote costs every retransmission
                exp_pulses = (ack == 8'h00) ? 1 + RETRANSMIT_TIMES : 1;
                if (s_tx_count - s_before != exp_pulses) begin
                    report_mismatch("s_tx_start count", s_tx_count - s_before, exp_pulses);
                end
                if (s_last_word !== word) begin
                    report_mismatch("s_byte_for_tx", s_last_word, word);
                end
            end else begin
                read_stream(word, nibble);
                if (g_tx_count - g_before != 1) begin
                    report_mismatch("g_tx_start count", g_tx_count - g_before, 1);
                end
                if (g_last_word !== W'(`BRIDGE_ACK_BYTE)) begin
                    report_mismatch("g_byte_for_tx", g_last_word, W'(`BRIDGE_ACK_BYTE));
                end
            end
        end
        $display("%0d transactions, %0d errors", NUM_LINES, err_count);
        if (err_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/bridge_stim.txt
// op (0 read, 1 write, 2 bad-start read, 3 bad-start write), id, data word,
// remote ack byte (CC, AA, 00 silent), status nibble expected on rD for reads
0 1 12345678 00 0
1 1 DEADBEEF CC 0
0 1 A5A5F00F 00 C
1 1 0BADC0DE 00 0
0 1 13579BDF 00 A
1 2 11111111 CC 0
2 1 22222222 00 0
0 1 2468ACE0 00 A
1 1 CAFEF00D AA 0
0 1 FFFF0001 00 A
1 1 80000001 CC 0
0 1 7E7E7E7E 00 C

//--- verilog.f
+incdir+rtl
rtl/bridge_pkg.sv
rtl/ctrl_frame_decoder.sv
rtl/bridge_sequencer.sv
rtl/write_forwarder.sv
rtl/read_responder.sv
rtl/uart_bridge_slave.sv
bench/uart_bridge_slave_tb.sv
